/* trig_unit.f */
trig_pkg.sv
trig_if.sv
fixed_mult.sv
sine_approx.sv
angle_reduce.sv
trig_regs.sv
trig_unit.sv
tb_trig_unit.sv

/* run_sim.sh */
#!/bin/sh
# build the trig_unit testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_trig_unit \
	-f trig_unit.f -o sim_trig_unit > build.log 2>&1 ||
	{ echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_trig_unit | tee sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }

/* tb_trig_unit.sv */
// tb_trig_unit: directed testbench for the AXI4-Lite sine and cosine unit with a bit-exact model
`timescale 1ns/1ns
`default_nettype none

module tb_trig_unit import trig_pkg::*; ();

	// ops per test: reset 3, sine 7, cosine 11, range 4, busy 2, random 200
	localparam int NUM_OPS = 227;
	localparam int CYCLE_LIMIT = 40 * NUM_OPS + 1000;
	localparam longint SAT_HI = (64'sd1 <<< (DATA_W - 1)) - 1;
	localparam longint SAT_LO = -(64'sd1 <<< (DATA_W - 1));

	logic                    clk;
	logic                    rst_n;
	logic [AXI_ADDR_W-1:0]   awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [AXI_DATA_W-1:0]   wdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [AXI_ADDR_W-1:0]   araddr;
	logic                    arvalid;
	logic                    arready;
	logic [AXI_DATA_W-1:0]   rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;

	int    checks;
	int    errors;
	int    checks_at_start;
	int    errors_at_start;
	int    cycles;
	bit    stall_en;
	string test_name;
	int    sine_angles[7] = '{0, 134, -134, 402, -402, 804, -804};
	int    cos_extra[4] = '{1600, -1600, 1608, -1608};
	int    bad_angles[4] = '{1700, -1700, 4000, -4000};

	trig_unit dut_i (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog sized from the op count
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	// product rounded to nearest and clamped to the word
	function automatic logic signed [DATA_W-1:0] round_mult(input logic signed [DATA_W-1:0] a,
			input logic signed [DATA_W-1:0] b);
		longint full;
		longint q;
		full = longint'(a) * longint'(b);
		q = (full + 128) >>> FRAC_W;
		if (q > SAT_HI) begin
			q = SAT_HI;
		end else if (q < SAT_LO) begin
			q = SAT_LO;
		end
		return DATA_W'(q);
	endfunction

	// cosine offset, then one 2pi step into [-pi, pi]
	function automatic logic signed [DATA_W-1:0] fold_angle(input logic signed [DATA_W-1:0] a,
			input bit cos_sel);
		logic signed [DATA_W-1:0] s;
		s = cos_sel ? a + C_HALF_PI : a;
		if (s > C_PI) begin
			s = s - C_TWO_PI;
		end else if (s < -C_PI) begin
			s = s + C_TWO_PI;
		end
		return s;
	endfunction

	// two-pass parabola, every sum wraps at 27 bits
	function automatic int expected_result(input int angle, input bit cos_sel);
		logic signed [DATA_W-1:0] x;
		logic signed [DATA_W-1:0] est;
		logic signed [DATA_W-1:0] esq;
		logic signed [DATA_W-1:0] sum;
		x = fold_angle(DATA_W'(angle), cos_sel);
		if (x < 0) begin
			est = round_mult(x, C_PARAB_LIN) + round_mult(round_mult(x, x), C_PARAB_SQ);
		end else begin
			est = round_mult(x, C_PARAB_LIN) - round_mult(round_mult(x, x), C_PARAB_SQ);
		end
		esq = round_mult(est, est);
		// est*|est|
		if (est < 0) begin
			esq = -esq;
		end
		sum = round_mult(esq - est, C_REFINE) + est;
		return int'(sum);
	endfunction

	task automatic compare(input string label, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("mismatch %s %s: expected %0d actual %0d", test_name, label, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		$display("%s: %0d checks, %0d errors", test_name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	// ready only moves on a rising edge, so a high ready seen here means a transfer next rise
	task automatic bus_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int   stall;
		logic aw_take;
		logic w_take;
		stall = stall_en ? int'($urandom_range(2, 0)) : 0;
		@(negedge clk);
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = '1;
		wvalid = 1'b1;
		while (awvalid || wvalid) begin
			aw_take = awvalid && awready;
			w_take = wvalid && wready;
			@(negedge clk);
			if (aw_take) begin
				awvalid = 1'b0;
			end
			if (w_take) begin
				wvalid = 1'b0;
			end
		end
		// hold off bready to stall the response
		repeat (stall) @(negedge clk);
		bready = 1'b1;
		while (!bvalid) @(negedge clk);
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic bus_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int   stall;
		logic ar_take;
		stall = stall_en ? int'($urandom_range(2, 0)) : 0;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		while (arvalid) begin
			ar_take = arready;
			@(negedge clk);
			if (ar_take) begin
				arvalid = 1'b0;
			end
		end
		repeat (stall) @(negedge clk);
		rready = 1'b1;
		while (!rvalid) @(negedge clk);
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// poll until busy drops, last status word returned
	task automatic wait_idle(output int status);
		logic [31:0] data;
		logic [1:0]  resp;
		data = 32'h1;
		while (data[0]) begin
			bus_read(REG_STATUS, data, resp);
		end
		status = int'(data);
	endtask

	// one full operation: select, angle, poll, result
	task automatic run_op(input int angle, input bit cos_sel, output int result,
			output int status);
		logic [31:0] data;
		logic [1:0]  resp;
		bus_write(REG_CTRL, 32'(cos_sel), resp);
		compare("ctrl write resp", int'(RESP_OKAY), int'(resp));
		bus_write(REG_ANGLE, 32'(angle), resp);
		compare($sformatf("angle %0d write resp", angle), int'(RESP_OKAY), int'(resp));
		wait_idle(status);
		bus_read(REG_RESULT, data, resp);
		result = $signed(data);
	endtask

	task automatic reset_state();
		logic [31:0] data;
		logic [1:0]  resp;
		begin_test("reset");
		compare("bvalid", 0, int'(bvalid));
		compare("rvalid", 0, int'(rvalid));
		bus_read(REG_STATUS, data, resp);
		compare("status", 0, int'(data));
		compare("status resp", int'(RESP_OKAY), int'(resp));
		bus_read(REG_RESULT, data, resp);
		compare("result", 0, int'(data));
		// offset 0x3 lies outside the map
		bus_read(AXI_ADDR_W'('h3), data, resp);
		compare("unmapped read resp", int'(RESP_SLVERR), int'(resp));
		end_test();
	endtask

	task automatic sine_fixed();
		int  got;
		int  status;
		real ideal;
		real err;
		begin_test("sine_fixed");
		foreach (sine_angles[i]) begin
			run_op(sine_angles[i], 1'b0, got, status);
			compare($sformatf("angle %0d status", sine_angles[i]), 2, status);
			compare($sformatf("angle %0d", sine_angles[i]),
				expected_result(sine_angles[i], 1'b0), got);
			// approximation error against the true sine of the Q8 angle
			ideal = 256.0 * $sin(real'(sine_angles[i]) / 256.0);
			err = real'(got) - ideal;
			checks++;
			if (err > 3.0 || err < -3.0) begin
				errors++;
				$display("mismatch %s angle %0d accuracy: expected %0.2f actual %0d",
					test_name, sine_angles[i], ideal, got);
			end
		end
		end_test();
	endtask

	task automatic cosine_fixed();
		int got;
		int status;
		int angles[$];
		begin_test("cosine_fixed");
		foreach (sine_angles[i]) angles.push_back(sine_angles[i]);
		foreach (cos_extra[i]) angles.push_back(cos_extra[i]);
		foreach (angles[i]) begin
			run_op(angles[i], 1'b1, got, status);
			compare($sformatf("angle %0d status", angles[i]), 2, status);
			compare($sformatf("angle %0d", angles[i]), expected_result(angles[i], 1'b1), got);
		end
		end_test();
	endtask

	task automatic out_of_range();
		logic [31:0] data;
		logic [1:0]  resp;
		int          prev;
		int          got;
		int          status;
		begin_test("out_of_range");
		bus_read(REG_RESULT, data, resp);
		prev = $signed(data);
		foreach (bad_angles[i]) begin
			run_op(bad_angles[i], 1'b0, got, status);
			// range_err set, done clear
			compare($sformatf("angle %0d status", bad_angles[i]), 4, status);
			compare($sformatf("angle %0d result kept", bad_angles[i]), prev, got);
		end
		end_test();
	endtask

	task automatic write_while_busy();
		logic [31:0] data;
		logic [1:0]  resp;
		int          status;
		begin_test("write_while_busy");
		bus_write(REG_CTRL, 32'h0, resp);
		bus_write(REG_ANGLE, 32'(300), resp);
		compare("first write resp", int'(RESP_OKAY), int'(resp));
		// core still running
		bus_write(REG_ANGLE, 32'(-100), resp);
		compare("second write resp", int'(RESP_SLVERR), int'(resp));
		wait_idle(status);
		compare("status", 2, status);
		// done clears once status has been read
		bus_read(REG_STATUS, data, resp);
		compare("status after read", 0, int'(data));
		bus_read(REG_RESULT, data, resp);
		compare("result", expected_result(300, 1'b0), $signed(data));
		bus_read(REG_ANGLE, data, resp);
		compare("angle kept", 300, $signed(data));
		end_test();
	endtask

	task automatic random_angles();
		int angle;
		bit cos_sel;
		int got;
		int status;
		begin_test("random_angles");
		stall_en = 1'b1;
		repeat (200) begin
			angle = int'($urandom_range(3216, 0)) - 1608;
			cos_sel = 1'($urandom_range(1, 0));
			run_op(angle, cos_sel, got, status);
			compare($sformatf("angle %0d cos %0d status", angle, cos_sel), 2, status);
			compare($sformatf("angle %0d cos %0d", angle, cos_sel),
				expected_result(angle, cos_sel), got);
		end
		stall_en = 1'b0;
		end_test();
	endtask

	initial begin
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		checks = 0;
		errors = 0;
		stall_en = 1'b0;
		void'($urandom(94973));
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_state();
		sine_fixed();
		cosine_fixed();
		out_of_range();
		write_while_busy();
		random_angles();
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* trig_unit.sv */
// trig_unit: memory-mapped fixed-point sine and cosine unit with an AXI4-Lite slave port
`timescale 1ns/1ns
`default_nettype none

module trig_unit import trig_pkg::*; #(
	parameter logic signed [DATA_W-1:0] C_LIN = C_PARAB_LIN,
	parameter logic signed [DATA_W-1:0] C_SQ = C_PARAB_SQ,
	parameter logic signed [DATA_W-1:0] C_REF = C_REFINE
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [AXI_ADDR_W-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [AXI_ADDR_W-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [AXI_DATA_W-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready
);

	logic                     core_in_valid;
	logic signed [DATA_W-1:0] core_in_angle;
	logic                     core_en;
	logic                     core_out_valid;
	logic signed [DATA_W-1:0] core_out_sin;

	axi_lite_if bus_if ();
	trig_req_if req_if ();

	// host side of the bus
	assign bus_if.awaddr = awaddr;
	assign bus_if.awvalid = awvalid;
	assign bus_if.wdata = wdata;
	assign bus_if.wstrb = wstrb;
	assign bus_if.wvalid = wvalid;
	assign bus_if.bready = bready;
	assign bus_if.araddr = araddr;
	assign bus_if.arvalid = arvalid;
	assign bus_if.rready = rready;
	assign awready = bus_if.awready;
	assign wready = bus_if.wready;
	assign bresp = bus_if.bresp;
	assign bvalid = bus_if.bvalid;
	assign arready = bus_if.arready;
	assign rdata = bus_if.rdata;
	assign rresp = bus_if.rresp;
	assign rvalid = bus_if.rvalid;

	trig_regs regs_i (
		.clk(clk), .rst_n(rst_n), .bus(bus_if.slave), .req(req_if.master)
	);

	angle_reduce reduce_i (
		.clk(clk), .rst_n(rst_n), .req(req_if.slave),
		.in_valid(core_in_valid), .in_angle(core_in_angle), .en(core_en),
		.out_valid(core_out_valid), .out_sin(core_out_sin)
	);

	sine_approx #(.C_LIN(C_LIN), .C_SQ(C_SQ), .C_REF(C_REF)) sine_i (
		.clk(clk), .rst_n(rst_n), .en(core_en),
		.in_valid(core_in_valid), .in_angle(core_in_angle),
		.out_valid(core_out_valid), .out_sin(core_out_sin)
	);

endmodule

`default_nettype wire

/* trig_regs.sv */
// trig_regs: AXI4-Lite slave with angle, control, status and result registers
`timescale 1ns/1ns
`default_nettype none

module trig_regs import trig_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	axi_lite_if.slave  bus,
	trig_req_if.master req
);

	// write address and data, captured apart
	logic                     aw_held;
	logic                     w_held;
	logic [AXI_ADDR_W-1:0]    awaddr_q;
	logic [DATA_W-1:0]        wdata_q;
	logic                     wstrb_full_q;
	logic                     aw_hs;
	logic                     w_hs;
	logic                     wr_go;
	logic [AXI_ADDR_W-1:0]    wr_addr;
	logic [DATA_W-1:0]        wr_data;
	logic                     wr_strb_full;
	logic                     wr_err;
	logic                     start;
	logic                     ctrl_we;
	logic                     bvalid_q;
	logic [1:0]               bresp_q;
	// read side
	logic                     ar_hs;
	logic                     rvalid_q;
	logic [1:0]               rresp_q;
	logic [AXI_DATA_W-1:0]    rdata_q;
	logic [AXI_DATA_W-1:0]    rd_word;
	logic                     rd_err;
	logic                     status_rd;
	// register file
	logic signed [DATA_W-1:0] angle_q;
	logic signed [DATA_W-1:0] result_q;
	logic                     cos_q;
	logic                     busy;
	logic                     done;
	logic                     range_err;
	logic                     req_valid_q;

	assign aw_hs = bus.awvalid && bus.awready;
	assign w_hs = bus.wvalid && bus.wready;
	// write fires once both halves are in, held or arriving now
	assign wr_go = (aw_hs || aw_held) && (w_hs || w_held);
	assign wr_addr = aw_held ? awaddr_q : bus.awaddr;
	assign wr_data = w_held ? wdata_q : bus.wdata[DATA_W-1:0];
	assign wr_strb_full = w_held ? wstrb_full_q : (bus.wstrb == '1);
	// nothing new until the pending response is taken
	assign bus.awready = !aw_held && !bvalid_q;
	assign bus.wready = !w_held && !bvalid_q;
	assign bus.bvalid = bvalid_q;
	assign bus.bresp = bresp_q;

	// write decode
	always_comb begin
		wr_err = 1'b0;
		start = 1'b0;
		ctrl_we = 1'b0;
		if (wr_go) begin
			if (!wr_strb_full) begin
				wr_err = 1'b1;
			end else begin
				case (wr_addr)
					// angle write while busy is refused
					REG_ANGLE: begin
						wr_err = busy;
						start = !busy;
					end
					REG_CTRL: ctrl_we = 1'b1;
					default: wr_err = 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (wr_go) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				bvalid_q <= 1'b1;
			end else begin
				if (aw_hs) begin
					aw_held <= 1'b1;
				end
				if (w_hs) begin
					w_held <= 1'b1;
				end
				if (bvalid_q && bus.bready) begin
					bvalid_q <= 1'b0;
				end
			end
		end
	end

	// write payload
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			awaddr_q <= bus.awaddr;
		end
		if (w_hs) begin
			wdata_q <= bus.wdata[DATA_W-1:0];
			wstrb_full_q <= (bus.wstrb == '1);
		end
		if (wr_go) begin
			bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// read decode, words sign-extended to the bus
	always_comb begin
		rd_word = '0;
		rd_err = 1'b0;
		case (bus.araddr)
			REG_ANGLE: rd_word = AXI_DATA_W'(angle_q);
			REG_CTRL: rd_word = AXI_DATA_W'(cos_q);
			REG_STATUS: rd_word = AXI_DATA_W'({range_err, done, busy});
			REG_RESULT: rd_word = AXI_DATA_W'(result_q);
			default: rd_err = 1'b1;
		endcase
	end

	assign ar_hs = bus.arvalid && bus.arready;
	assign status_rd = ar_hs && (bus.araddr == REG_STATUS);
	assign bus.arready = !rvalid_q;
	assign bus.rvalid = rvalid_q;
	assign bus.rresp = rresp_q;
	assign bus.rdata = rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
		end else if (ar_hs) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && bus.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= rd_word;
			rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// register file and operation tracking
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			angle_q <= '0;
			result_q <= '0;
			cos_q <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			range_err <= 1'b0;
			req_valid_q <= 1'b0;
		end else begin
			req_valid_q <= start;
			if (ctrl_we) begin
				cos_q <= wr_data[0];
			end
			// status read clears done, a new result wins
			if (status_rd) begin
				done <= 1'b0;
			end
			if (start) begin
				angle_q <= wr_data;
				busy <= 1'b1;
				done <= 1'b0;
				range_err <= 1'b0;
			end
			if (req.rsp_valid) begin
				busy <= 1'b0;
				if (req.rsp_err) begin
					range_err <= 1'b1;
				end else begin
					result_q <= req.rsp_result;
					done <= 1'b1;
				end
			end
		end
	end

	assign req.req_valid = req_valid_q;
	assign req.req_angle = angle_q;
	assign req.req_cos = cos_q;

	// a response only ever answers an issued request
	a_rsp_busy: assert property (@(posedge clk) disable iff (!rst_n) req.rsp_valid |-> busy);

endmodule

`default_nettype wire

/* angle_reduce.sv */
// angle_reduce: range check, cosine offset and fold into [-pi, pi], plus result return path
`timescale 1ns/1ns
`default_nettype none

module angle_reduce import trig_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	trig_req_if.slave                req,
	output logic                     in_valid,
	output logic signed [DATA_W-1:0] in_angle,
	output logic                     en,
	input  logic                     out_valid,
	input  logic signed [DATA_W-1:0] out_sin
);

	logic                     out_of_range;
	logic signed [DATA_W-1:0] shifted;
	logic signed [DATA_W-1:0] folded;
	logic                     rej_q;

	// only |angle| <= 2pi is accepted
	assign out_of_range = (req.req_angle > C_TWO_PI) || (req.req_angle < -C_TWO_PI);

	// cos(x) = sin(x + pi/2)
	assign shifted = req.req_cos ? req.req_angle + C_HALF_PI : req.req_angle;

	// one 2pi step is enough for the accepted range
	always_comb begin
		if (shifted > C_PI) begin
			folded = shifted - C_TWO_PI;
		end else if (shifted < -C_PI) begin
			folded = shifted + C_TWO_PI;
		end else begin
			folded = shifted;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid <= 1'b0;
			in_angle <= '0;
			rej_q <= 1'b0;
		end else begin
			in_valid <= req.req_valid && !out_of_range;
			rej_q <= req.req_valid && out_of_range;
			if (req.req_valid && !out_of_range) begin
				in_angle <= folded;
			end
		end
	end

	// register block always takes a result, core never stalls
	assign en = 1'b1;

	// core results and rejections share the response pulse
	assign req.rsp_valid = out_valid || rej_q;
	assign req.rsp_err = rej_q;
	assign req.rsp_result = out_sin;

	// one operation in flight, so a rejection never meets a core result
	a_no_collide: assert property (@(posedge clk) disable iff (!rst_n) !(rej_q && out_valid));

endmodule

`default_nettype wire

/* sine_approx.sv */
// sine_approx: pipelined two-pass parabolic sine over [-pi, pi] with valid and stall enable
`timescale 1ns/1ns
`default_nettype none

module sine_approx import trig_pkg::*; #(
	parameter logic signed [DATA_W-1:0] C_LIN = C_PARAB_LIN,
	parameter logic signed [DATA_W-1:0] C_SQ = C_PARAB_SQ,
	parameter logic signed [DATA_W-1:0] C_REF = C_REFINE
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     en,
	input  logic                     in_valid,
	input  logic signed [DATA_W-1:0] in_angle,
	output logic                     out_valid,
	output logic signed [DATA_W-1:0] out_sin
);

	// linear term waits for the squared-term scale
	localparam int LIN_DLY = MULT_LAT;
	// input sign is needed at the estimate register
	localparam int SIGN_DLY = 2 * MULT_LAT;
	// estimate waits for est^2, difference and refine scale
	localparam int EST_DLY = 2 * MULT_LAT + 1;

	logic signed [DATA_W-1:0] x_sq;
	logic signed [DATA_W-1:0] lin;
	logic signed [DATA_W-1:0] sq_term;
	logic signed [DATA_W-1:0] est;
	logic signed [DATA_W-1:0] est_sq;
	logic signed [DATA_W-1:0] est_sq_s;
	logic signed [DATA_W-1:0] diff;
	logic signed [DATA_W-1:0] refine;
	logic signed [DATA_W-1:0] lin_d [LIN_DLY];
	logic signed [DATA_W-1:0] est_d [EST_DLY];
	logic [SIGN_DLY-1:0]      sign_d;
	logic [SINE_LAT-1:0]      vld_sr;

	// first pass, x^2 and 4/pi * x side by side
	fixed_mult #(.SQUARE(1'b1), .COEFF('0)) x_sq_i (
		.clk(clk), .rst_n(rst_n), .en(en), .a(in_angle), .p(x_sq)
	);
	fixed_mult #(.SQUARE(1'b0), .COEFF(C_LIN)) lin_i (
		.clk(clk), .rst_n(rst_n), .en(en), .a(in_angle), .p(lin)
	);
	// 4/pi^2 * x^2
	fixed_mult #(.SQUARE(1'b0), .COEFF(C_SQ)) sq_term_i (
		.clk(clk), .rst_n(rst_n), .en(en), .a(x_sq), .p(sq_term)
	);
	// second pass, est^2
	fixed_mult #(.SQUARE(1'b1), .COEFF('0)) est_sq_i (
		.clk(clk), .rst_n(rst_n), .en(en), .a(est), .p(est_sq)
	);
	// 0.225 * (est*|est| - est)
	fixed_mult #(.SQUARE(1'b0), .COEFF(C_REF)) refine_i (
		.clk(clk), .rst_n(rst_n), .en(en), .a(diff), .p(refine)
	);

	// est*|est|, sign follows the estimate
	assign est_sq_s = est_d[MULT_LAT-1][DATA_W-1] ? -est_sq : est_sq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lin_d <= '{default: '0};
			est_d <= '{default: '0};
			sign_d <= '0;
			vld_sr <= '0;
			est <= '0;
			diff <= '0;
			out_sin <= '0;
		end else if (en) begin
			// alignment delays
			lin_d[0] <= lin;
			for (int i = 1; i < LIN_DLY; i++) begin
				lin_d[i] <= lin_d[i-1];
			end
			est_d[0] <= est;
			for (int i = 1; i < EST_DLY; i++) begin
				est_d[i] <= est_d[i-1];
			end
			sign_d <= {sign_d[SIGN_DLY-2:0], in_angle[DATA_W-1]};
			vld_sr <= {vld_sr[SINE_LAT-2:0], in_valid};
			// negative x flips the parabola
			if (sign_d[SIGN_DLY-1]) begin
				est <= lin_d[LIN_DLY-1] + sq_term;
			end else begin
				est <= lin_d[LIN_DLY-1] - sq_term;
			end
			diff <= est_sq_s - est_d[MULT_LAT-1];
			out_sin <= refine + est_d[EST_DLY-1];
		end
	end

	assign out_valid = vld_sr[SINE_LAT-1];

	// result comes out after SINE_LAT enabled edges, stalls stretch it
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid && en) |-> ##1 (en [->SINE_LAT-1]) ##1 out_valid);

endmodule

`default_nettype wire

/* fixed_mult.sv */
// fixed_mult: two-stage signed Q18.8 multiply, square or constant scale, rounded and saturated
`timescale 1ns/1ns
`default_nettype none

module fixed_mult import trig_pkg::*; #(
	// set to square the operand, clear to scale by COEFF
	parameter bit SQUARE = 1'b0,
	parameter logic signed [DATA_W-1:0] COEFF = '0
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     en,
	input  logic signed [DATA_W-1:0] a,
	output logic signed [DATA_W-1:0] p
);

	// clamp values of the result word
	localparam logic signed [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
	localparam logic signed [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};
	// half an LSB of the Q8 result
	localparam logic signed [PROD_W-1:0] RND_HALF = PROD_W'(1 << (FRAC_W - 1));

	logic signed [PROD_W-1:0] op_a;
	logic signed [PROD_W-1:0] op_b;
	logic signed [PROD_W-1:0] prod_q;
	logic signed [PROD_W-1:0] rnd;
	logic signed [PROD_W-1:0] shr;
	logic [PROD_W-DATA_W:0]   upper;
	logic                     ovf;

	// both operands sign-extended to product width
	assign op_a = a;
	assign op_b = SQUARE ? a : COEFF;

	// round to nearest, then drop the extra fraction bits
	assign rnd = prod_q + RND_HALF;
	assign shr = rnd >>> FRAC_W;

	// fits only if everything above the result sign bit copies it
	assign upper = shr[PROD_W-1:DATA_W-1];
	assign ovf = !((&upper) || !(|upper));

	// stage 1, full product
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_q <= '0;
		end else if (en) begin
			prod_q <= op_a * op_b;
		end
	end

	// stage 2, rounded and clamped Q8 result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			p <= '0;
		end else if (en) begin
			if (ovf) begin
				p <= shr[PROD_W-1] ? SAT_MIN : SAT_MAX;
			end else begin
				p <= shr[DATA_W-1:0];
			end
		end
	end

	// no unknowns leak out of the pipe once running
	a_p_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(p));

endmodule

`default_nettype wire

/* trig_if.sv */
// bus and request interfaces linking the register block, range stage and sine core
`timescale 1ns/1ns
`default_nettype none

interface axi_lite_if import trig_pkg::*; ();

	// write address
	logic [AXI_ADDR_W-1:0]   awaddr;
	logic                    awvalid;
	logic                    awready;
	// write data, strobes must be all ones
	logic [AXI_DATA_W-1:0]   wdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic                    wvalid;
	logic                    wready;
	// write response
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	// read address
	logic [AXI_ADDR_W-1:0]   araddr;
	logic                    arvalid;
	logic                    arready;
	// read data and response
	logic [AXI_DATA_W-1:0]   rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;

	modport master (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

endinterface

interface trig_req_if import trig_pkg::*; ();

	// one-cycle request pulse with angle and function select
	logic                     req_valid;
	logic signed [DATA_W-1:0] req_angle;
	logic                     req_cos;
	// one-cycle response pulse, err marks a rejected angle
	logic                     rsp_valid;
	logic signed [DATA_W-1:0] rsp_result;
	logic                     rsp_err;

	modport master (
		output req_valid, req_angle, req_cos,
		input  rsp_valid, rsp_result, rsp_err
	);

	modport slave (
		input  req_valid, req_angle, req_cos,
		output rsp_valid, rsp_result, rsp_err
	);

endinterface

`default_nettype wire

/* trig_pkg.sv */
// trig_pkg: shared widths, Q8 constants, register map and latencies of the sine/cosine unit
`default_nettype none

package trig_pkg;

	// angle and result words are signed Q18.8
	localparam int DATA_W = 27;
	localparam int FRAC_W = 8;
	// full signed product of two data words
	localparam int PROD_W = 2 * DATA_W;

	// parabola coefficients in Q8
	// 1.27323954 = 4/pi
	localparam logic signed [DATA_W-1:0] C_PARAB_LIN = DATA_W'(326);
	// 0.405284735 = 4/pi^2
	localparam logic signed [DATA_W-1:0] C_PARAB_SQ = DATA_W'(104);
	// refinement weight 0.225
	localparam logic signed [DATA_W-1:0] C_REFINE = DATA_W'(58);

	// angle constants in Q8
	localparam logic signed [DATA_W-1:0] C_PI = DATA_W'(804);
	localparam logic signed [DATA_W-1:0] C_HALF_PI = DATA_W'(402);
	localparam logic signed [DATA_W-1:0] C_TWO_PI = DATA_W'(1608);

	// multiplier is two register stages
	localparam int MULT_LAT = 2;
	// four multiplies in series plus estimate, difference and sum registers
	localparam int SINE_LAT = 4 * MULT_LAT + 3;

	// bus field widths
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	// register offsets
	localparam logic [AXI_ADDR_W-1:0] REG_ANGLE = AXI_ADDR_W'('h0);
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = AXI_ADDR_W'('h4);
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = AXI_ADDR_W'('h8);
	localparam logic [AXI_ADDR_W-1:0] REG_RESULT = AXI_ADDR_W'('hC);

	// response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
